/* build.f */
hdl/key_extract_pkg.sv
hdl/key_table.sv
hdl/ctrl_table_writer.sv
hdl/key_extractor.sv
hdl/key_extract_top.sv
tests/key_extract_sva.sv
tests/key_extract_tb.sv

/* hdl/ctrl_table_writer.sv */
`timescale 1ns/10ps

module ctrl_table_writer #(
	parameter int stage_id = 0,
	parameter int module_id = 1
) (
	input logic clk,
	input logic rst_n,

	input key_extract_pkg::ctrl_beat_t ctrl_in,
	output key_extract_pkg::ctrl_beat_t ctrl_out,

	output key_extract_pkg::off_wr_t off_wr,
	output key_extract_pkg::mask_wr_t mask_wr
);

	import key_extract_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WR_OFF,
		ST_WR_MASK
	} state_t;

	localparam logic [4:0] STAGE = 5'(stage_id);
	localparam logic [2:0] MODULE = 3'(module_id);

	state_t state;

	logic [7:0] mod_id;
	logic [3:0] resv;
	logic [15:0] flag;
	logic is_header;
	logic [CTRL_DATA_WIDTH-1:0] tdata_swapped;
	logic [TABLE_ADDR_WIDTH-1:0] wr_idx;

	// ==============================
	// header decode
	// ==============================
	assign mod_id = ctrl_in.tdata[MOD_ID_LSB +: 8];
	assign resv = ctrl_in.tdata[RESV_LSB +: 4];
	assign flag = ctrl_in.tdata[FLAG_LSB +: 16];

	assign is_header = ctrl_in.tvalid &&
		mod_id[7:3] == STAGE &&
		mod_id[2:0] == MODULE &&
		flag == CTRL_FLAG_KEY;

	// byte 0 of the beat ends up as the top byte
	assign tdata_swapped = {<<8{ctrl_in.tdata}};

	// ==============================
	// control fsm
	// ==============================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			wr_idx <= '0;
			ctrl_out <= '0;
			off_wr <= '0;
			mask_wr <= '0;
		end else begin
			// write strobes last a single cycle
			off_wr.en <= 1'b0;
			mask_wr.en <= 1'b0;
			ctrl_out.tvalid <= 1'b0;

			case (state)
				ST_IDLE: begin
					if (is_header) begin
						wr_idx <= ctrl_in.tdata[INDEX_LSB +: TABLE_ADDR_WIDTH];
						// header-only packet carries no entries
						if (!ctrl_in.tlast) begin
							state <= (resv == 4'd0) ? ST_WR_OFF : ST_WR_MASK;
						end
					end else begin
						ctrl_out <= ctrl_in;
					end
				end

				ST_WR_OFF, ST_WR_MASK: begin
					if (ctrl_in.tvalid) begin
						off_wr.en <= (state == ST_WR_OFF);
						off_wr.addr <= wr_idx;
						off_wr.data <= tdata_swapped[CTRL_DATA_WIDTH-1 -: $bits(key_off_t)];

						mask_wr.en <= (state == ST_WR_MASK);
						mask_wr.addr <= wr_idx;
						mask_wr.data <= tdata_swapped[CTRL_DATA_WIDTH-1 -: $bits(key_mask_t)];

						// next beat goes to the following entry
						wr_idx <= wr_idx + 1'b1;
						if (ctrl_in.tlast) begin
							state <= ST_IDLE;
						end
					end
				end

				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

/* hdl/key_extract_pkg.sv */
package key_extract_pkg;

	// ==============================
	// widths and layout
	// ==============================
	localparam int CTRL_DATA_WIDTH = 512;
	localparam int CTRL_USER_WIDTH = 128;
	localparam int CTRL_KEEP_WIDTH = CTRL_DATA_WIDTH / 8;

	localparam int NUM_PER_TYPE = 8;
	localparam int PHV_LEN = 1024;
	// whatever is left below the containers
	localparam int META_WIDTH = PHV_LEN - (48 + 32 + 16) * NUM_PER_TYPE;
	localparam int CONT_IDX_WIDTH = 3;

	localparam int TABLE_DEPTH = 32;
	localparam int TABLE_ADDR_WIDTH = 5;

	localparam int VLAN_WIDTH = 12;
	localparam int VLAN_IDX_LSB = 4;

	// ==============================
	// control header fields
	// ==============================
	localparam int MOD_ID_LSB = 368;
	localparam int RESV_LSB = 376;
	localparam int FLAG_LSB = 320;
	localparam int INDEX_LSB = 384;
	localparam logic [15:0] CTRL_FLAG_KEY = 16'hf2f1;

	// ==============================
	// types
	// ==============================
	// container 0 sits at the top of each group
	typedef struct packed {
		logic [0:NUM_PER_TYPE-1][47:0] c6;
		logic [0:NUM_PER_TYPE-1][31:0] c4;
		logic [0:NUM_PER_TYPE-1][15:0] c2;
		logic [META_WIDTH-1:0] meta;
	} phv_t;

	typedef struct packed {
		logic [47:0] c6_a;
		logic [47:0] c6_b;
		logic [31:0] c4_a;
		logic [31:0] c4_b;
		logic [15:0] c2_a;
		logic [15:0] c2_b;
	} key_t;

	typedef key_t key_mask_t;

	// one container selector per key field
	typedef struct packed {
		logic [CONT_IDX_WIDTH-1:0] c6_a;
		logic [CONT_IDX_WIDTH-1:0] c6_b;
		logic [CONT_IDX_WIDTH-1:0] c4_a;
		logic [CONT_IDX_WIDTH-1:0] c4_b;
		logic [CONT_IDX_WIDTH-1:0] c2_a;
		logic [CONT_IDX_WIDTH-1:0] c2_b;
	} key_off_t;

	typedef struct packed {
		phv_t phv;
		logic [VLAN_WIDTH-1:0] vlan;
	} lookup_req_t;

	typedef struct packed {
		logic [CTRL_DATA_WIDTH-1:0] tdata;
		logic [CTRL_USER_WIDTH-1:0] tuser;
		logic [CTRL_KEEP_WIDTH-1:0] tkeep;
		logic tvalid;
		logic tlast;
	} ctrl_beat_t;

	typedef struct packed {
		logic en;
		logic [TABLE_ADDR_WIDTH-1:0] addr;
		key_off_t data;
	} off_wr_t;

	typedef struct packed {
		logic en;
		logic [TABLE_ADDR_WIDTH-1:0] addr;
		key_mask_t data;
	} mask_wr_t;

endpackage

/* hdl/key_extract_top.sv */
`timescale 1ns/10ps

module key_extract_top #(
	parameter int stage_id = 0,
	parameter int module_id = 1
) (
	input logic clk,
	input logic rst_n,

	input key_extract_pkg::lookup_req_t lookup_in,
	input logic valid_in,
	output logic ready_out,

	output key_extract_pkg::phv_t phv_out,
	output key_extract_pkg::key_t key_out_masked,
	output logic valid_out,
	input logic ready_in,

	input key_extract_pkg::ctrl_beat_t ctrl_in,
	output key_extract_pkg::ctrl_beat_t ctrl_out
);

	import key_extract_pkg::*;

	off_wr_t off_wr;
	mask_wr_t mask_wr;
	key_off_t key_off;
	key_mask_t key_mask;

	logic advance;
	logic [TABLE_ADDR_WIDTH-1:0] rd_addr;

	// one level stalls the whole lookup path
	assign advance = ready_in;
	assign ready_out = advance;
	assign rd_addr = lookup_in.vlan[VLAN_IDX_LSB +: TABLE_ADDR_WIDTH];

	// ==============================
	// control path
	// ==============================
	ctrl_table_writer #(
		.stage_id(stage_id),
		.module_id(module_id)
	) i_writer (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl_in(ctrl_in),
		.ctrl_out(ctrl_out),
		.off_wr(off_wr),
		.mask_wr(mask_wr)
	);

	key_table #(
		.entry_t(key_off_t),
		.depth(TABLE_DEPTH)
	) i_off_table (
		.clk(clk),
		.wr_en(off_wr.en),
		.wr_addr(off_wr.addr),
		.wr_data(off_wr.data),
		.rd_en(advance),
		.rd_addr(rd_addr),
		.rd_data(key_off)
	);

	key_table #(
		.entry_t(key_mask_t),
		.depth(TABLE_DEPTH)
	) i_mask_table (
		.clk(clk),
		.wr_en(mask_wr.en),
		.wr_addr(mask_wr.addr),
		.wr_data(mask_wr.data),
		.rd_en(advance),
		.rd_addr(rd_addr),
		.rd_data(key_mask)
	);

	// ==============================
	// lookup path
	// ==============================
	key_extractor i_extractor (
		.clk(clk),
		.rst_n(rst_n),
		.lookup_in(lookup_in),
		.valid_in(valid_in),
		.advance(advance),
		.key_off(key_off),
		.key_mask(key_mask),
		.phv_out(phv_out),
		.key_out_masked(key_out_masked),
		.valid_out(valid_out)
	);

endmodule

/* hdl/key_extractor.sv */
`timescale 1ns/10ps

module key_extractor (
	input logic clk,
	input logic rst_n,

	input key_extract_pkg::lookup_req_t lookup_in,
	input logic valid_in,
	input logic advance,

	// table outputs, one cycle behind the request
	input key_extract_pkg::key_off_t key_off,
	input key_extract_pkg::key_mask_t key_mask,

	output key_extract_pkg::phv_t phv_out,
	output key_extract_pkg::key_t key_out_masked,
	output logic valid_out
);

	import key_extract_pkg::*;

	phv_t phv_s1;
	logic valid_s1;
	key_t key_sel;

	// ==============================
	// valids
	// ==============================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_s1 <= 1'b0;
			valid_out <= 1'b0;
		end else if (advance) begin
			valid_s1 <= valid_in;
			valid_out <= valid_s1;
		end
	end

	// ==============================
	// payload
	// ==============================
	// stage 1 lines up the phv with the table read
	always_ff @(posedge clk) begin
		if (advance) begin
			phv_s1 <= lookup_in.phv;
		end
	end

	always_comb begin
		key_sel.c6_a = phv_s1.c6[key_off.c6_a];
		key_sel.c6_b = phv_s1.c6[key_off.c6_b];
		key_sel.c4_a = phv_s1.c4[key_off.c4_a];
		key_sel.c4_b = phv_s1.c4[key_off.c4_b];
		key_sel.c2_a = phv_s1.c2[key_off.c2_a];
		key_sel.c2_b = phv_s1.c2[key_off.c2_b];
	end

	// stage 2
	always_ff @(posedge clk) begin
		if (advance) begin
			phv_out <= phv_s1;
			key_out_masked <= key_sel & key_mask;
		end
	end

endmodule

/* hdl/key_table.sv */
`timescale 1ns/10ps

module key_table #(
	parameter type entry_t = logic [7:0],
	parameter int depth = key_extract_pkg::TABLE_DEPTH
) (
	input logic clk,

	input logic wr_en,
	input logic [key_extract_pkg::TABLE_ADDR_WIDTH-1:0] wr_addr,
	input entry_t wr_data,

	input logic rd_en,
	input logic [key_extract_pkg::TABLE_ADDR_WIDTH-1:0] rd_addr,
	output entry_t rd_data
);

	entry_t mem [depth];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// read register holds while the pipeline stalls
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"

verilator --binary --assert -j 0 -f build.f --top-module key_extract_tb -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^all tests passed$"; then
	exit 0
fi
exit 1

/* tests/key_extract_sva.sv */
`timescale 1ns/10ps

module key_extract_sva (
	input logic clk,
	input logic rst_n,
	input logic valid_out,
	input logic ready_in,
	input logic ctrl_in_valid,
	input logic ctrl_out_valid
);

	// first sampled edge after reset release
	a_valid_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !valid_out)
		else $error("valid_out high in the first cycle after reset");

	a_ctrl_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !ctrl_out_valid)
		else $error("ctrl_out.tvalid high during reset");

	a_ctrl_from_input: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl_out_valid |-> $past(ctrl_in_valid))
		else $error("ctrl_out.tvalid without ctrl_in.tvalid one cycle earlier");

	// a stalled result stays on the output
	a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		valid_out && !ready_in |=> valid_out)
		else $error("valid_out dropped while ready_in was low");

endmodule

bind key_extract_top key_extract_sva i_sva (
	.clk(clk),
	.rst_n(rst_n),
	.valid_out(valid_out),
	.ready_in(ready_in),
	.ctrl_in_valid(ctrl_in.tvalid),
	.ctrl_out_valid(ctrl_out.tvalid)
);

/* tests/key_extract_tb.sv */
`timescale 1ns/10ps

module key_extract_tb;

	import key_extract_pkg::*;

	localparam int STAGE_ID = 0;
	localparam int MODULE_ID = 1;
	localparam int NUM_LOOKUPS = 48;
	localparam int NUM_STALL_LOOKUPS = 120;
	// full run is about 330 cycles
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int C4_TOP = PHV_LEN - 48 * NUM_PER_TYPE;
	localparam int C2_TOP = C4_TOP - 32 * NUM_PER_TYPE;

	typedef struct packed {
		phv_t phv;
		key_t key;
		int adv;
	} lookup_exp_t;

	typedef struct packed {
		ctrl_beat_t beat;
		int cycle;
	} ctrl_exp_t;

	logic clk;
	logic rst_n;
	lookup_req_t lookup_in;
	logic valid_in;
	logic ready_out;
	phv_t phv_out;
	key_t key_out_masked;
	logic valid_out;
	logic ready_in;
	ctrl_beat_t ctrl_in;
	ctrl_beat_t ctrl_out;

	key_off_t off_shadow [TABLE_DEPTH];
	key_mask_t mask_shadow [TABLE_DEPTH];
	lookup_exp_t lookup_q [$];
	ctrl_exp_t ctrl_q [$];

	logic [31:0] rng_state = 32'd69297;
	int cycle = 0;
	int adv_count = 0;
	logic last_adv = 1'b0;
	int value_errs = 0;
	int other_errs = 0;

	key_extract_top #(
		.stage_id(STAGE_ID),
		.module_id(MODULE_ID)
	) i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.lookup_in(lookup_in),
		.valid_in(valid_in),
		.ready_out(ready_out),
		.phv_out(phv_out),
		.key_out_masked(key_out_masked),
		.valid_out(valid_out),
		.ready_in(ready_in),
		.ctrl_in(ctrl_in),
		.ctrl_out(ctrl_out)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ==============================
	// random values
	// ==============================
	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function logic [31:0] next_rand();
		rng_state = lcg(rng_state);
		return rng_state;
	endfunction

	function logic [1023:0] rand_wide();
		logic [1023:0] v;
		for (int i = 0; i < 32; i++) begin
			v = {v[991:0], next_rand()};
		end
		return v;
	endfunction

	function ctrl_beat_t rand_beat();
		ctrl_beat_t b;
		logic [1023:0] w;
		w = rand_wide();
		b.tdata = w[511:0];
		b.tuser = w[639:512];
		b.tkeep = w[703:640];
		b.tvalid = 1'b1;
		b.tlast = w[704];
		return b;
	endfunction

	function ctrl_beat_t make_header(input logic [4:0] stage, input logic [2:0] modl,
			input logic [15:0] flag, input logic [3:0] resv, input logic [4:0] start);
		ctrl_beat_t b;
		b = rand_beat();
		b.tdata[MOD_ID_LSB +: 8] = {stage, modl};
		b.tdata[RESV_LSB +: 4] = resv;
		b.tdata[FLAG_LSB +: 16] = flag;
		b.tdata[INDEX_LSB +: 8] = {3'b000, start};
		b.tlast = 1'b0;
		return b;
	endfunction

	// tdata byte 0 carries the top byte of the entry word
	function automatic logic [CTRL_DATA_WIDTH-1:0] to_tdata(input logic [CTRL_DATA_WIDTH-1:0] word);
		logic [CTRL_DATA_WIDTH-1:0] t;
		for (int b = 0; b < CTRL_KEEP_WIDTH; b++) begin
			t[8*b +: 8] = word[CTRL_DATA_WIDTH-8-8*b +: 8];
		end
		return t;
	endfunction

	// ==============================
	// reference model and checks
	// ==============================
	function automatic key_t ref_key(input phv_t phv, input key_off_t off, input key_mask_t mask);
		logic [PHV_LEN-1:0] flat;
		key_t k;
		flat = phv;
		// container n of a group counts down from the top of that group
		k.c6_a = 48'(flat >> (PHV_LEN - 48 * (int'(off.c6_a) + 1)));
		k.c6_b = 48'(flat >> (PHV_LEN - 48 * (int'(off.c6_b) + 1)));
		k.c4_a = 32'(flat >> (C4_TOP - 32 * (int'(off.c4_a) + 1)));
		k.c4_b = 32'(flat >> (C4_TOP - 32 * (int'(off.c4_b) + 1)));
		k.c2_a = 16'(flat >> (C2_TOP - 16 * (int'(off.c2_a) + 1)));
		k.c2_b = 16'(flat >> (C2_TOP - 16 * (int'(off.c2_b) + 1)));
		return k & mask;
	endfunction

	task automatic check_phv(input string name, input phv_t got, input phv_t exp);
		if (got !== exp) begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			value_errs++;
		end
	endtask

	task automatic check_key(input string name, input key_t got, input key_t exp);
		if (got !== exp) begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			value_errs++;
		end
	endtask

	task automatic check_ctrl(input string name, input ctrl_beat_t got, input ctrl_beat_t exp);
		if (got !== exp) begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			value_errs++;
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			value_errs++;
		end
	endtask

	// ==============================
	// stimulus
	// ==============================
	task automatic drive_ctrl(input ctrl_beat_t beat);
		@(posedge clk);
		#2;
		ctrl_in = beat;
	endtask

	task automatic forward_beat(input ctrl_beat_t beat);
		drive_ctrl(beat);
		ctrl_q.push_back('{beat: beat, cycle: cycle + 1});
	endtask

	task automatic write_table(input logic is_mask, input logic [4:0] start, input int count);
		ctrl_beat_t beat;
		logic [CTRL_DATA_WIDTH-1:0] word;
		logic [1023:0] w;
		logic [31:0] r;
		logic [TABLE_ADDR_WIDTH-1:0] addr;
		drive_ctrl(make_header(5'(STAGE_ID), 3'(MODULE_ID), CTRL_FLAG_KEY,
			is_mask ? 4'h3 : 4'h0, start));
		for (int i = 0; i < count; i++) begin
			beat = rand_beat();
			w = rand_wide();
			word = w[511:0];
			addr = start + 5'(i);
			if (is_mask) begin
				mask_shadow[addr] = w[1023 -: $bits(key_mask_t)];
				word[CTRL_DATA_WIDTH-1 -: $bits(key_mask_t)] = mask_shadow[addr];
			end else begin
				r = next_rand();
				off_shadow[addr] = r[31:14];
				word[CTRL_DATA_WIDTH-1 -: $bits(key_off_t)] = off_shadow[addr];
			end
			beat.tdata = to_tdata(word);
			beat.tlast = (i == count - 1);
			drive_ctrl(beat);
		end
		drive_ctrl('0);
	endtask

	task automatic send_lookup(input logic stall_en);
		lookup_req_t req;
		logic [31:0] r;
		logic accepted;
		logic [TABLE_ADDR_WIDTH-1:0] idx;
		req.phv = rand_wide();
		r = next_rand();
		req.vlan = r[31:20];
		idx = req.vlan[VLAN_IDX_LSB +: TABLE_ADDR_WIDTH];
		accepted = 1'b0;
		while (!accepted) begin
			@(posedge clk);
			#2;
			r = next_rand();
			lookup_in = req;
			valid_in = 1'b1;
			ready_in = stall_en ? (r[31:30] != 2'b00) : 1'b1;
			accepted = ready_in;
		end
		lookup_q.push_back('{phv: req.phv, key: ref_key(req.phv, off_shadow[idx],
			mask_shadow[idx]), adv: adv_count + 2});
	endtask

	task automatic drain_lookups();
		@(posedge clk);
		#2;
		valid_in = 1'b0;
		ready_in = 1'b1;
		while (lookup_q.size() != 0) begin
			@(posedge clk);
		end
	endtask

	// ==============================
	// cycle count and compare
	// ==============================
	always @(posedge clk) begin
		cycle <= cycle + 1;
		last_adv <= ready_in;
		if (ready_in) begin
			adv_count <= adv_count + 1;
		end
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("tests failed");
			$finish;
		end
	end

	always @(negedge clk) begin : compare
		lookup_exp_t le;
		ctrl_exp_t ce;
		// ready_out mirrors ready_in at all times
		check_level("ready_out", ready_out, ready_in);
		if (!rst_n) begin
			if (cycle > 1 && (valid_out !== 1'b0 || ctrl_out.tvalid !== 1'b0)) begin
				$display("valid_out or ctrl_out.tvalid active during reset");
				other_errs++;
			end
		end else begin
			// a new result is loaded only on an advancing edge
			if (valid_out && last_adv) begin
				if (lookup_q.size() == 0) begin
					$display("result on valid_out with no request outstanding");
					other_errs++;
				end else begin
					le = lookup_q.pop_front();
					check_phv("phv_out", phv_out, le.phv);
					check_key("key_out_masked", key_out_masked, le.key);
					if (adv_count != le.adv) begin
						$display("result came at advancing edge %0d instead of %0d",
							adv_count, le.adv);
						other_errs++;
					end
				end
			end
			if (ctrl_out.tvalid) begin
				if (ctrl_q.size() == 0) begin
					$display("unexpected beat on ctrl_out at cycle %0d", cycle);
					other_errs++;
				end else begin
					ce = ctrl_q.pop_front();
					check_ctrl("ctrl_out", ctrl_out, ce.beat);
					if (cycle != ce.cycle) begin
						$display("forwarded beat came at cycle %0d instead of %0d", cycle, ce.cycle);
						other_errs++;
					end
				end
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		valid_in = 1'b0;
		ready_in = 1'b0;
		lookup_in = '0;
		ctrl_in = '0;
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// wrong stage, wrong module, wrong flag, then plain traffic
		forward_beat(make_header(5'd1, 3'(MODULE_ID), CTRL_FLAG_KEY, 4'h0, 5'd0));
		forward_beat(make_header(5'(STAGE_ID), 3'd2, CTRL_FLAG_KEY, 4'h0, 5'd0));
		forward_beat(make_header(5'(STAGE_ID), 3'(MODULE_ID), 16'h1234, 4'h0, 5'd0));
		for (int i = 0; i < 6; i++) begin
			forward_beat(rand_beat());
		end
		drive_ctrl('0);
		while (ctrl_q.size() != 0) begin
			@(posedge clk);
		end

		// full bursts that wrap around the table end
		write_table(1'b0, 5'd9, TABLE_DEPTH);
		write_table(1'b1, 5'd27, TABLE_DEPTH);
		repeat (3) @(posedge clk);

		for (int i = 0; i < NUM_LOOKUPS; i++) begin
			send_lookup(1'b0);
		end
		drain_lookups();
		for (int i = 0; i < NUM_STALL_LOOKUPS; i++) begin
			send_lookup(1'b1);
		end
		drain_lookups();
		repeat (4) @(posedge clk);

		$display("errors: %0d value, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
